/* vlog.f */
hdl/icache_pkg.sv
hdl/icache_ifs.sv
hdl/icache_array.sv
hdl/refill_request.sv
hdl/fill_collector.sv
hdl/icache_refill_top.sv
tests/axi_lite_rd_model.sv
tests/tb_icache_refill.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the cache refill testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/100ps \
	-f vlog.f --top-module tb_icache_refill \
	-Mdir "$build_dir" -o sim_icache_refill
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/sim_icache_refill" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

grep -q "^PASS: all tests$" "$log_file"
if [ $? -ne 0 ]; then
	echo "Pass line not found in $log_file"
	exit 1
fi

echo "Simulation passed"
exit 0

/* tests/tb_icache_refill.sv */
// ======================================================================
// Fetch testbench for the refill cache, one fetch outstanding at a time
// Each table entry is allowed 400 cycles before the run is stopped
// ======================================================================
module tb_icache_refill;
	timeunit 1ns;
	timeprecision 100ps;
	import icache_pkg::*;

	// ======================================================================
	// Stimulus table
	// ======================================================================

	// Expected result of the first lookup of an entry
	localparam int EXP_MISS = 0;
	localparam int EXP_HIT = 1;
	localparam int EXP_ANY = 2;

	localparam int N_CASES = 18;
	localparam int SEED = 83610;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLE_LIMIT = 400 * N_CASES + RESET_CYCLES + 16;

	// Cold line in set 0, four sets filled back to back, then three lines in set 5
	localparam addr_t CASE_ADDR [N_CASES] = '{
		32'h0000_1000, 32'h0000_1004, 32'h0000_1008, 32'h0000_100C,
		32'h0000_2010, 32'h0000_2024, 32'h0000_2038, 32'h0000_204C,
		32'h0000_2010, 32'h0000_2024, 32'h0000_2038, 32'h0000_204C,
		32'h0000_3050, 32'h0001_3054, 32'h0002_3058,
		32'h0000_3050, 32'h0001_3054, 32'h0002_3058
	};
	localparam int CASE_FIRST [N_CASES] = '{
		EXP_MISS, EXP_HIT, EXP_HIT, EXP_HIT,
		EXP_MISS, EXP_MISS, EXP_MISS, EXP_MISS,
		EXP_ANY, EXP_ANY, EXP_ANY, EXP_ANY,
		EXP_MISS, EXP_MISS, EXP_MISS,
		EXP_ANY, EXP_ANY, EXP_ANY
	};
	// Retry until hit, or issue once and leave the fill running
	localparam bit CASE_RETRY [N_CASES] = '{
		1'b1, 1'b1, 1'b1, 1'b1,
		1'b0, 1'b0, 1'b0, 1'b0,
		1'b1, 1'b1, 1'b1, 1'b1,
		1'b1, 1'b1, 1'b1,
		1'b1, 1'b1, 1'b1
	};
	// AR handshakes expected while the entry runs, -1 where not checked
	localparam int CASE_AR [N_CASES] = '{
		4, 0, 0, 0,
		-1, -1, -1, -1,
		-1, -1, -1, -1,
		4, 4, 4,
		-1, -1, -1
	};

	logic clk;
	logic rst;
	logic fetch_valid;
	addr_t fetch_addr;
	logic fetch_ready;
	logic resp_valid;
	logic resp_hit;
	word_t resp_data;
	addr_t araddr;
	logic [2:0] arprot;
	logic arvalid;
	logic arready;
	word_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	int ar_count = 0;
	int cycles = 0;

	initial clk = 1'b0;
	always #20 clk = ~clk;

	icache_refill_top i_dut (
		.clk         (clk),
		.rst         (rst),
		.fetch_valid (fetch_valid),
		.fetch_addr  (fetch_addr),
		.fetch_ready (fetch_ready),
		.resp_valid  (resp_valid),
		.resp_hit    (resp_hit),
		.resp_data   (resp_data),
		.araddr      (araddr),
		.arprot      (arprot),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready)
	);

	axi_lite_rd_model i_mem (
		.clk     (clk),
		.rst     (rst),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	// ======================================================================
	// Helpers
	// ======================================================================

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
			fail_run("Stopping at the first mismatch");
		end
	endtask

	// Upper half is address bits 17 to 2, lower half is their inverse
	function automatic word_t expected_word(input addr_t a);
		return {a[17:2], ~a[17:2]};
	endfunction

	// Holds the fetch until it is taken, then samples the response one cycle later
	task automatic fetch_once(input addr_t a, output logic hit, output word_t data);
		@(posedge clk);
		fetch_valid <= 1'b1;
		fetch_addr <= a;
		@(negedge clk);
		while (!fetch_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		fetch_valid <= 1'b0;
		@(negedge clk);
		check_value(32'(resp_valid), 32'd1, $sformatf("resp_valid after fetch of %h", a));
		hit = resp_hit;
		data = resp_data;
	endtask

	// AR handshakes seen at the DUT ports
	always @(posedge clk) begin
		if (arvalid && arready) begin
			ar_count <= ar_count + 1;
			// Refill reads are instruction, unprivileged and secure accesses
			check_value(32'(arprot), 32'h4, "arprot on AR handshake");
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			fail_run($sformatf("Timeout: the run did not finish within %0d cycles", cycles));
		end
	end

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		logic hit;
		word_t data;
		int ar_start;
		void'($urandom(SEED));
		$timeformat(-9, 1, " ns", 0);
		rst <= 1'b1;
		fetch_valid <= 1'b0;
		fetch_addr <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		// Nothing may move on either side before the first fetch
		repeat (8) begin
			@(negedge clk);
			check_value(32'(arvalid), 32'd0, "arvalid before first fetch");
			check_value(32'(resp_valid), 32'd0, "resp_valid before first fetch");
		end
		for (int i = 0; i < N_CASES; i++) begin
			ar_start = ar_count;
			fetch_once(CASE_ADDR[i], hit, data);
			if (CASE_FIRST[i] != EXP_ANY) begin
				check_value(32'(hit), 32'(CASE_FIRST[i]),
					$sformatf("case %0d first lookup hit", i));
			end
			// Misses while the line is pending must not start a second fill
			while (CASE_RETRY[i] && !hit) begin
				fetch_once(CASE_ADDR[i], hit, data);
			end
			if (hit) begin
				check_value(data, expected_word(CASE_ADDR[i]),
					$sformatf("case %0d data at %h", i, CASE_ADDR[i]));
			end
			if (CASE_AR[i] >= 0) begin
				check_value(32'(ar_count - ar_start), 32'(CASE_AR[i]),
					$sformatf("case %0d AR handshakes", i));
			end
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

/* tests/axi_lite_rd_model.sv */
// ======================================================================
// AXI4-Lite read slave, in-order, with random AR stalls and 1-6 cycle R latency
// Data at address A is {A[17:2], ~A[17:2]}; rresp is always OKAY
// ======================================================================
module axi_lite_rd_model (
	input  logic              clk,
	input  logic              rst,
	input  icache_pkg::addr_t araddr,
	input  logic              arvalid,
	output logic              arready,
	output icache_pkg::word_t rdata,
	output logic [1:0]        rresp,
	output logic              rvalid,
	input  logic              rready
);
	timeunit 1ns;
	timeprecision 100ps;
	import icache_pkg::*;

	// Accepted reads waiting for their data, oldest first
	addr_t pend_addr [$];
	int pend_due [$];

	// Each word carries its own address bits, so a misplaced beat shows up at once
	function automatic word_t mem_word(input addr_t a);
		return {a[17:2], ~a[17:2]};
	endfunction

	initial begin
		int now;
		arready <= 1'b0;
		rvalid <= 1'b0;
		rdata <= '0;
		rresp <= 2'b00;
		now = 0;
		forever begin
			@(posedge clk);
			if (rst) begin
				arready <= 1'b0;
				rvalid <= 1'b0;
				pend_addr.delete();
				pend_due.delete();
				now = 0;
			end else begin
				now++;
				// Latency is counted from the AR handshake
				if (arvalid && arready) begin
					pend_addr.push_back(araddr);
					pend_due.push_back(now + int'($urandom_range(1, 6)));
				end
				// Stall the address channel about one cycle in four
				arready <= $urandom_range(0, 3) != 0;
				// Data goes out strictly in AR order
				if (pend_addr.size() > 0 && pend_due[0] <= now && (!rvalid || rready)) begin
					rvalid <= 1'b1;
					rdata <= mem_word(pend_addr.pop_front());
					rresp <= 2'b00;
					void'(pend_due.pop_front());
				end else if (rready) begin
					rvalid <= 1'b0;
				end
			end
		end
	end

endmodule

/* hdl/icache_refill_top.sv */
// ======================================================================
// Instruction cache with AXI4-Lite line refill, up to four lines in flight
// A miss gives no data; the fetcher must retry the same address
// ======================================================================
module icache_refill_top (
	input  logic              clk,
	input  logic              rst,
	// Fetch port
	input  logic              fetch_valid,
	input  icache_pkg::addr_t fetch_addr,
	output logic              fetch_ready,
	output logic              resp_valid,
	output logic              resp_hit,
	output icache_pkg::word_t resp_data,
	// AXI4-Lite read address channel
	output icache_pkg::addr_t araddr,
	output logic [2:0]        arprot,
	output logic              arvalid,
	input  logic              arready,
	// AXI4-Lite read data channel
	input  icache_pkg::word_t rdata,
	input  logic [1:0]        rresp,
	input  logic              rvalid,
	output logic              rready
);
	import icache_pkg::*;

	// Miss report from the array to the request stage
	logic miss_valid;
	line_addr_t miss_line;

	// Slot release from the collector to the request stage
	logic slot_done;
	logic [SLOT_W-1:0] slot_done_id;

	fill_tag_if tag_if ();
	line_write_if wr_if ();

	// Instruction fetch, unprivileged, secure
	assign arprot = 3'b100;

	// The collector never stalls; rresp is ignored and the beat is kept as data
	assign rready = 1'b1;

	icache_array i_array (
		.clk         (clk),
		.rst         (rst),
		.fetch_valid (fetch_valid),
		.fetch_addr  (fetch_addr),
		.fetch_ready (fetch_ready),
		.resp_valid  (resp_valid),
		.resp_hit    (resp_hit),
		.resp_data   (resp_data),
		.miss_valid  (miss_valid),
		.miss_line   (miss_line),
		.wr          (wr_if.sink)
	);

	refill_request i_request (
		.clk          (clk),
		.rst          (rst),
		.miss_valid   (miss_valid),
		.miss_line    (miss_line),
		.slot_done    (slot_done),
		.slot_done_id (slot_done_id),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.tags         (tag_if.producer)
	);

	fill_collector i_collector (
		.clk          (clk),
		.rst          (rst),
		.rdata        (rdata),
		.rvalid       (rvalid),
		.tags         (tag_if.consumer),
		.wr           (wr_if.source),
		.slot_done    (slot_done),
		.slot_done_id (slot_done_id)
	);

endmodule

/* hdl/fill_collector.sv */
// ======================================================================
// Gathers R beats into per-slot line buffers using the tag queue head
// Every R beat is taken at once, so rready may be tied high
// ======================================================================
module fill_collector (
	input  logic                          clk,
	input  logic                          rst,
	input  icache_pkg::word_t             rdata,
	input  logic                          rvalid,
	fill_tag_if.consumer                  tags,
	line_write_if.source                  wr,
	output logic                          slot_done,
	output logic [icache_pkg::SLOT_W-1:0] slot_done_id
);
	import icache_pkg::*;

	// Per-slot beat valid bits and line buffers
	logic [BUNDLES-1:0] beat_v [SLOTS];
	line_data_t slot_buf [SLOTS];

	// Beat acceptance
	logic take;
	logic [BUNDLES-1:0] beat_set;
	line_data_t merged;
	logic complete;

	// Victim way source
	logic [LFSR_W-1:0] lfsr;

	// Outgoing line register
	logic done_q;
	line_addr_t out_line;
	line_data_t out_data;
	logic [WAY_W-1:0] out_way;
	logic [SLOT_W-1:0] out_slot;

	// ======================================================================
	// Beat acceptance
	// ======================================================================

	// The head tag names the slot and bundle of the arriving beat
	assign take = rvalid && tags.valid;
	assign tags.pop = take;

	// Valid bits of the slot as they will be once this beat lands
	assign beat_set = beat_v[tags.slot] | (BUNDLES'(1) << tags.beat);

	// The line is complete when this beat fills its last hole
	assign complete = take && beat_set == '1;

	// Slot buffer with the new bundle merged in
	always_comb begin
		merged = slot_buf[tags.slot];
		merged[tags.beat] = rdata;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < SLOTS; s++) begin
				beat_v[s] <= '0;
			end
			done_q <= 1'b0;
			lfsr <= LFSR_SEED;
		end else begin
			// Free-running, so the victim depends on when the line finishes
			lfsr <= {lfsr[LFSR_W-2:0], lfsr[LFSR_W-1] ^ lfsr[LFSR_W-4]};
			done_q <= complete;
			// A finished slot starts empty for its next line
			if (take) begin
				beat_v[tags.slot] <= complete ? '0 : beat_set;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			slot_buf[tags.slot] <= merged;
		end
		// Capture the whole line with its address and victim
		if (complete) begin
			out_line <= tags.line_addr;
			out_data <= merged;
			out_way <= lfsr[WAY_W-1:0];
			out_slot <= tags.slot;
		end
	end

	// ======================================================================
	// Line write and slot release, one cycle after the last beat
	// ======================================================================

	assign wr.valid = done_q;
	assign wr.set = out_line[SET_W-1:0];
	assign wr.tag = out_line[$bits(line_addr_t)-1:SET_W];
	assign wr.way = out_way;
	assign wr.data = out_data;

	assign slot_done = done_q;
	assign slot_done_id = out_slot;

endmodule

/* hdl/refill_request.sv */
// ======================================================================
// Allocates fill slots on a miss and issues four in-order beat reads
// A miss is dropped when its line is already pending or no slot is free
// ======================================================================
module refill_request (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          miss_valid,
	input  icache_pkg::line_addr_t        miss_line,
	input  logic                          slot_done,
	input  logic [icache_pkg::SLOT_W-1:0] slot_done_id,
	output icache_pkg::addr_t             araddr,
	output logic                          arvalid,
	input  logic                          arready,
	fill_tag_if.producer                  tags
);
	import icache_pkg::*;

	// Slot state
	logic [SLOTS-1:0] busy;
	line_addr_t slot_line [SLOTS];
	logic dup_hit;
	logic free_any;
	logic [SLOT_W-1:0] free_id;
	logic alloc;

	// Queue of slots waiting for their address beats
	logic [SLOT_W-1:0] pq_mem [SLOTS];
	logic [SLOT_W-1:0] pq_wr;
	logic [SLOT_W-1:0] pq_rd;
	logic [SLOT_W:0] pq_cnt;
	logic [SLOT_W-1:0] ar_slot;
	logic [BEAT_W-1:0] ar_beat;
	logic ar_fire;
	logic ar_last;

	// Beat tag queue, one entry per accepted AR
	logic [SLOT_W-1:0] tq_slot [TAGQ_DEPTH];
	logic [BEAT_W-1:0] tq_beat [TAGQ_DEPTH];
	line_addr_t tq_line [TAGQ_DEPTH];
	logic [TAGQ_W-1:0] tq_wr;
	logic [TAGQ_W-1:0] tq_rd;
	logic [TAGQ_W:0] tq_cnt;
	logic tq_pop;

	// ======================================================================
	// Slot allocation
	// ======================================================================

	// Scan downwards so the lowest free slot is the one left in free_id
	always_comb begin
		dup_hit = 1'b0;
		free_any = 1'b0;
		free_id = '0;
		for (int s = SLOTS - 1; s >= 0; s--) begin
			if (busy[s] && slot_line[s] == miss_line) begin
				dup_hit = 1'b1;
			end
			if (!busy[s]) begin
				free_any = 1'b1;
				free_id = SLOT_W'(s);
			end
		end
	end

	assign alloc = miss_valid && !dup_hit && free_any;

	// The released slot is still busy here, so it can never equal free_id
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= '0;
		end else begin
			if (slot_done) begin
				busy[slot_done_id] <= 1'b0;
			end
			if (alloc) begin
				busy[free_id] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (alloc) begin
			slot_line[free_id] <= miss_line;
			pq_mem[pq_wr] <= free_id;
		end
	end

	// ======================================================================
	// AR sequencer
	// ======================================================================

	// Head of the pending queue drives AR directly, so arvalid rises the cycle after the miss
	assign ar_slot = pq_mem[pq_rd];
	assign arvalid = pq_cnt != '0;
	assign araddr = {slot_line[ar_slot], ar_beat, 2'b00};
	assign ar_fire = arvalid && arready;
	assign ar_last = ar_fire && ar_beat == BEAT_W'(BUNDLES - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			pq_wr <= '0;
			pq_rd <= '0;
			pq_cnt <= '0;
			ar_beat <= '0;
		end else begin
			if (alloc) begin
				pq_wr <= pq_wr + 1'b1;
			end
			// Head leaves once bundle 3 has been accepted
			if (ar_last) begin
				pq_rd <= pq_rd + 1'b1;
			end
			if (ar_fire) begin
				ar_beat <= ar_last ? '0 : ar_beat + 1'b1;
			end
			case ({alloc, ar_last})
				2'b10: pq_cnt <= pq_cnt + 1'b1;
				2'b01: pq_cnt <= pq_cnt - 1'b1;
				default: ;
			endcase
		end
	end

	// ======================================================================
	// Beat tag queue
	// ======================================================================

	// Read data returns in AR order, so the head always names the next beat
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			tq_slot[tq_wr] <= ar_slot;
			tq_beat[tq_wr] <= ar_beat;
			tq_line[tq_wr] <= slot_line[ar_slot];
		end
	end

	assign tq_pop = tags.pop && tags.valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			tq_wr <= '0;
			tq_rd <= '0;
			tq_cnt <= '0;
		end else begin
			if (ar_fire) begin
				tq_wr <= tq_wr + 1'b1;
			end
			if (tq_pop) begin
				tq_rd <= tq_rd + 1'b1;
			end
			case ({ar_fire, tq_pop})
				2'b10: tq_cnt <= tq_cnt + 1'b1;
				2'b01: tq_cnt <= tq_cnt - 1'b1;
				default: ;
			endcase
		end
	end

	assign tags.valid = tq_cnt != '0;
	assign tags.slot = tq_slot[tq_rd];
	assign tags.beat = tq_beat[tq_rd];
	assign tags.line_addr = tq_line[tq_rd];

endmodule

/* hdl/icache_array.sv */
// ======================================================================
// Two-way tag and data store with a one-cycle registered lookup
// A line write stalls fetch for that cycle and always wins the arrays
// ======================================================================
module icache_array (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   fetch_valid,
	input  icache_pkg::addr_t      fetch_addr,
	output logic                   fetch_ready,
	output logic                   resp_valid,
	output logic                   resp_hit,
	output icache_pkg::word_t      resp_data,
	output logic                   miss_valid,
	output icache_pkg::line_addr_t miss_line,
	line_write_if.sink             wr
);
	import icache_pkg::*;

	// Valid bits per way, one per set
	logic [SETS-1:0] vld [WAYS];
	tag_t tag_mem [WAYS][SETS];
	line_data_t data_mem [WAYS][SETS];

	// Registered lookup stage
	logic lk_valid;
	addr_t lk_addr;
	logic [SET_W-1:0] lk_set;
	tag_t lk_tag;
	logic [BEAT_W-1:0] lk_bundle;
	logic lk_hit;
	logic [WAY_W-1:0] lk_way;

	// The fetcher is held off only while a refilled line is written
	assign fetch_ready = !wr.valid;

	// ======================================================================
	// Lookup register
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			lk_valid <= 1'b0;
		end else begin
			lk_valid <= fetch_valid && fetch_ready;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_valid && fetch_ready) begin
			lk_addr <= fetch_addr;
		end
	end

	// Split the held address into its fields
	assign lk_set = lk_addr[SET_W+3:4];
	assign lk_tag = lk_addr[31:SET_W+4];
	assign lk_bundle = lk_addr[3:2];

	// Compare both ways; at most one can match since a line is never filled twice
	always_comb begin
		lk_hit = 1'b0;
		lk_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (vld[w][lk_set] && tag_mem[w][lk_set] == lk_tag) begin
				lk_hit = 1'b1;
				lk_way = WAY_W'(w);
			end
		end
	end

	// Response goes out in the cycle after the fetch was taken
	assign resp_valid = lk_valid;
	assign resp_hit = lk_hit;
	assign resp_data = data_mem[lk_way][lk_set][lk_bundle];

	// A miss pulse carries the line address to the refill request stage
	assign miss_valid = lk_valid && !lk_hit;
	assign miss_line = lk_addr[31:4];

	// ======================================================================
	// Line write
	// ======================================================================

	// All entries start invalid
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < WAYS; w++) begin
				vld[w] <= '0;
			end
		end else if (wr.valid) begin
			vld[wr.way][wr.set] <= 1'b1;
		end
	end

	// Tag and data follow the valid bit into the chosen way
	always_ff @(posedge clk) begin
		if (wr.valid) begin
			tag_mem[wr.way][wr.set] <= wr.tag;
			data_mem[wr.way][wr.set] <= wr.data;
		end
	end

endmodule

/* hdl/icache_ifs.sv */
// ======================================================================
// Internal links of the refill path, never seen at the top level
// A line write is taken by the array in the cycle valid is high
// ======================================================================

// Head of the beat tag queue, read by the collector
interface fill_tag_if;
	import icache_pkg::*;

	// Head entry is present
	logic valid;
	// Slot that owns the next returning beat
	logic [SLOT_W-1:0] slot;
	// Bundle position of that beat within its line
	logic [BEAT_W-1:0] beat;
	// Line being refilled into that slot
	line_addr_t line_addr;
	// Head is consumed together with an R beat
	logic pop;

	modport producer (
		output valid,
		output slot,
		output beat,
		output line_addr,
		input  pop
	);

	modport consumer (
		input  valid,
		input  slot,
		input  beat,
		input  line_addr,
		output pop
	);
endinterface

// Finished line travelling from the collector into the cache arrays
interface line_write_if;
	import icache_pkg::*;

	logic valid;
	logic [SET_W-1:0] set;
	// Victim way chosen by the collector
	logic [WAY_W-1:0] way;
	tag_t tag;
	line_data_t data;

	modport source (
		output valid,
		output set,
		output way,
		output tag,
		output data
	);

	modport sink (
		input  valid,
		input  set,
		input  way,
		input  tag,
		input  data
	);
endinterface

/* hdl/icache_pkg.sv */
// ======================================================================
// Geometry of the two-way instruction cache and its refill path
// Address split is tag [31:8], set [7:4], bundle [3:2], byte [1:0]
// ======================================================================
package icache_pkg;

	// ======================================================================
	// Sizes
	// ======================================================================

	// Beats per line, one 32-bit bundle each
	localparam int BUNDLES = 4;
	localparam int BEAT_W = 2;

	// Sets, indexed by address bits 7 to 4
	localparam int SETS = 16;
	localparam int SET_W = 4;

	// Associativity
	localparam int WAYS = 2;
	localparam int WAY_W = 1;

	// Fill slots, which bound the number of lines in flight
	localparam int SLOTS = 4;
	localparam int SLOT_W = 2;

	// Tag queue holds one entry for every beat of every slot
	localparam int TAGQ_DEPTH = 16;
	localparam int TAGQ_W = 4;

	// Victim way generator, polynomial x^17 + x^14 + 1
	localparam int LFSR_W = 17;
	localparam logic [LFSR_W-1:0] LFSR_SEED = 17'h1ACE5;

	// ======================================================================
	// Types
	// ======================================================================

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;

	// Bundle 0 sits in the low word of the line
	typedef word_t [BUNDLES-1:0] line_data_t;

	// Address bits 31 to 8
	typedef logic [23:0] tag_t;

	// Address bits 31 to 4
	typedef logic [27:0] line_addr_t;

endpackage
